// File: common/npu_pkg.sv
// Widths, instruction layout, opcodes and host register map shared by the NPU slice
// Design files refer to these by scoped name
`default_nettype none

package npu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] ucode_ptr_t;
    typedef logic [7:0]  data_t;
    typedef logic [7:0]  scr_addr_t;
    typedef logic [31:0] instr_t;

    // Low bit of each instruction field
    localparam int OPC_LSB = 28;
    localparam int DST_LSB = 16;
    localparam int SRC_LSB = 8;
    localparam int IMM_LSB = 0;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_COPY = 4'd2,
        OP_MULI = 4'd3
    } opcode_t;

    // Right shift applied to MULI products before saturation
    localparam int REQUANT_SHIFT = 4;

    // Host register indices, taken from address bits 5:2
    localparam reg_idx_t REG_CTRL        = 4'd0;
    localparam reg_idx_t REG_STATUS      = 4'd1;
    localparam reg_idx_t REG_UCODE_BASE  = 4'd2;
    localparam reg_idx_t REG_UCODE_LEN   = 4'd3;
    localparam reg_idx_t REG_UCODE_WADDR = 4'd4;
    localparam reg_idx_t REG_UCODE_WDATA = 4'd5;
    localparam reg_idx_t REG_SCR_ADDR    = 4'd6;
    localparam reg_idx_t REG_SCR_DATA    = 4'd7;

endpackage

`default_nettype wire

// File: rtl/npu_sram.sv
// Simple dual-port memory, one write port and one registered read port
// Used for both the microcode store and the scratchpad
`timescale 1ns/10ps
`default_nettype none

module npu_sram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 8
) (
    input  wire                clk,
    input  wire                wr_en,
    input  wire [ADDR_W-1:0]   wr_addr,
    input  wire [DATA_W-1:0]   wr_data,
    input  wire                rd_en,
    input  wire [ADDR_W-1:0]   rd_addr,
    output logic [DATA_W-1:0]  rd_data
);

    logic [DATA_W-1:0] mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Output holds until the next read
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/npu_regs.sv
// Host register file: config writes, memory load paths, start pulse and busy/done status
// The host port is always ready; reads return one cycle after arvalid
`timescale 1ns/10ps
`default_nettype none

module npu_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire npu_pkg::word_t  s_axi_awaddr,
    input  wire npu_pkg::word_t  s_axi_wdata,
    input  wire                  s_axi_wvalid,
    input  wire npu_pkg::word_t  s_axi_araddr,
    input  wire                  s_axi_arvalid,
    output npu_pkg::word_t       s_axi_rdata,
    output logic                 s_axi_rvalid,
    output logic                 ucode_wr_en,
    output npu_pkg::ucode_ptr_t  ucode_wr_addr,
    output npu_pkg::word_t       ucode_wr_data,
    output logic                 scr_wr_en,
    output logic                 scr_rd_en,
    output npu_pkg::scr_addr_t   scr_addr,
    output npu_pkg::data_t       scr_wr_data,
    input  wire npu_pkg::data_t  scr_rd_data,
    output logic                 start,
    output npu_pkg::ucode_ptr_t  ucode_base,
    output npu_pkg::ucode_ptr_t  ucode_len,
    input  wire                  prog_end,
    output logic                 busy,
    output logic                 done
);

    npu_pkg::reg_idx_t  wr_idx;
    npu_pkg::reg_idx_t  rd_idx;
    logic               wr_open;
    logic               start_req;
    npu_pkg::word_t     rd_word;
    npu_pkg::word_t     rd_word_q;
    logic               rd_scr_q;

    assign wr_idx  = s_axi_awaddr[5:2];
    assign rd_idx  = s_axi_araddr[5:2];
    // Config and memory writes only land while idle
    assign wr_open = s_axi_wvalid && !busy;
    assign start_req = wr_open && (wr_idx == npu_pkg::REG_CTRL) && s_axi_wdata[0]
                       && (ucode_len != '0);

    assign ucode_wr_en   = wr_open && (wr_idx == npu_pkg::REG_UCODE_WDATA);
    assign ucode_wr_data = s_axi_wdata;
    assign scr_wr_en     = wr_open && (wr_idx == npu_pkg::REG_SCR_DATA);
    assign scr_wr_data   = s_axi_wdata[7:0];
    assign scr_rd_en     = s_axi_arvalid && (rd_idx == npu_pkg::REG_SCR_DATA);

    // ============================================================
    // Register writes
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ucode_base    <= '0;
            ucode_len     <= '0;
            ucode_wr_addr <= '0;
            scr_addr      <= '0;
        end else if (wr_open) begin
            case (wr_idx)
                npu_pkg::REG_UCODE_BASE:  ucode_base <= s_axi_wdata[15:0];
                npu_pkg::REG_UCODE_LEN:   ucode_len <= s_axi_wdata[15:0];
                npu_pkg::REG_UCODE_WADDR: ucode_wr_addr <= s_axi_wdata[15:0];
                npu_pkg::REG_UCODE_WDATA: ucode_wr_addr <= ucode_wr_addr + 1'b1;
                npu_pkg::REG_SCR_ADDR:    scr_addr <= s_axi_wdata[7:0];
                default: ;
            endcase
        end
    end

    // Busy rises with the start pulse, done replaces it at program end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= start_req;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (prog_end) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ============================================================
    // Register reads
    // ============================================================
    always_comb begin
        case (rd_idx)
            npu_pkg::REG_STATUS:      rd_word = {30'd0, done, busy};
            npu_pkg::REG_UCODE_BASE:  rd_word = {16'd0, ucode_base};
            npu_pkg::REG_UCODE_LEN:   rd_word = {16'd0, ucode_len};
            npu_pkg::REG_UCODE_WADDR: rd_word = {16'd0, ucode_wr_addr};
            npu_pkg::REG_SCR_ADDR:    rd_word = {24'd0, scr_addr};
            default:                  rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axi_rvalid <= 1'b0;
            rd_scr_q     <= 1'b0;
        end else begin
            s_axi_rvalid <= s_axi_arvalid;
            rd_scr_q     <= scr_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (s_axi_arvalid) begin
            rd_word_q <= rd_word;
        end
    end

    // Scratchpad byte arrives from the memory's own output register
    assign s_axi_rdata = rd_scr_q ? {24'd0, scr_rd_data} : rd_word_q;

endmodule

`default_nettype wire

// File: controller/ucode_fetch.sv
// Microcode fetcher: reads len program words from base and offers each on a req/ack link
// The final word of the program is flagged as last
`timescale 1ns/10ps
`default_nettype none

module ucode_fetch #(
    parameter int UCODE_ADDR_W = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire npu_pkg::ucode_ptr_t  ucode_base,
    input  wire npu_pkg::ucode_ptr_t  ucode_len,
    output logic                      mem_rd_en,
    output logic [UCODE_ADDR_W-1:0]   mem_rd_addr,
    input  wire npu_pkg::word_t       mem_rd_data,
    output logic                      out_req,
    input  wire                       out_ack,
    output npu_pkg::instr_t           out_instr,
    output logic                      out_last
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        OFFER,
        RELEASE
    } state_t;

    state_t               state;
    npu_pkg::ucode_ptr_t  ptr;
    npu_pkg::ucode_ptr_t  remaining;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ptr       <= '0;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    ptr       <= ucode_base;
                    remaining <= ucode_len;
                    state     <= READ;
                end
                READ: state <= OFFER;
                OFFER: if (out_ack) begin
                    state <= RELEASE;
                end
                // Wait for the queue to drop ack before the next word
                RELEASE: if (!out_ack) begin
                    if (out_last) begin
                        state <= IDLE;
                    end else begin
                        ptr       <= ptr + 1'b1;
                        remaining <= remaining - 1'b1;
                        state     <= READ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign mem_rd_en   = (state == READ);
    assign mem_rd_addr = ptr[UCODE_ADDR_W-1:0];
    assign out_req     = (state == OFFER);
    // Memory output holds the word while req is up
    assign out_instr   = mem_rd_data;
    assign out_last    = (remaining == 16'd1);

endmodule

`default_nettype wire

// File: controller/instr_queue.sv
// Instruction queue between fetcher and engine, four-phase req/ack on both sides
// Withholds in_ack when full
`timescale 1ns/10ps
`default_nettype none

module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_req,
    output logic                   in_ack,
    input  wire npu_pkg::instr_t   in_instr,
    input  wire                    in_last,
    output logic                   out_req,
    input  wire                    out_ack,
    output npu_pkg::instr_t        out_instr,
    output logic                   out_last
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    npu_pkg::instr_t   q_instr [QUEUE_DEPTH];
    logic              q_last  [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = in_req && !in_ack && (count != CNT_W'(QUEUE_DEPTH));
    // Entry leaves when the engine has acked it
    assign pop  = out_req && out_ack;

    always_ff @(posedge clk) begin
        if (push) begin
            q_instr[wr_ptr] <= in_instr;
            q_last[wr_ptr]  <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (push) in_ack <= 1'b1;
            else if (!in_req) in_ack <= 1'b0;
            if (pop) out_req <= 1'b0;
            else if (!out_req && !out_ack && (count != '0)) out_req <= 1'b1;
        end
    end

    assign out_instr = q_instr[rd_ptr];
    assign out_last  = q_last[rd_ptr];

endmodule

`default_nettype wire

// File: engine/vec_engine.sv
// Vector engine: executes byte instructions on its scratchpad, one at a time
// Host owns the scratchpad ports whenever the engine is idle
`timescale 1ns/10ps
`default_nettype none

module vec_engine (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      in_req,
    output logic                     in_ack,
    input  wire npu_pkg::instr_t     in_instr,
    input  wire                      in_last,
    output logic                     prog_end,
    input  wire                      host_wr_en,
    input  wire                      host_rd_en,
    input  wire npu_pkg::scr_addr_t  host_addr,
    input  wire npu_pkg::data_t      host_wr_data,
    output npu_pkg::data_t           host_rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        EXEC,
        ACK
    } state_t;

    state_t              state;
    npu_pkg::instr_t     instr_q;
    logic                last_q;
    npu_pkg::opcode_t    opcode;
    npu_pkg::scr_addr_t  dst_addr;
    npu_pkg::scr_addr_t  src_addr;
    npu_pkg::data_t      imm;
    npu_pkg::data_t      scr_rd_data;
    npu_pkg::data_t      result;
    logic [15:0]         product;
    logic [15:0]         scaled;
    logic                op_writes;
    logic                host_sel;

    assign opcode   = npu_pkg::opcode_t'(instr_q[npu_pkg::OPC_LSB +: 4]);
    assign dst_addr = instr_q[npu_pkg::DST_LSB +: 8];
    assign src_addr = instr_q[npu_pkg::SRC_LSB +: 8];
    assign imm      = instr_q[npu_pkg::IMM_LSB +: 8];

    // Requantize: scale by imm, shift, clamp to a byte
    assign product = scr_rd_data * imm;
    assign scaled  = product >> npu_pkg::REQUANT_SHIFT;

    always_comb begin
        result    = scr_rd_data;
        op_writes = 1'b1;
        case (opcode)
            npu_pkg::OP_ADDI: result = scr_rd_data + imm;
            npu_pkg::OP_COPY: result = scr_rd_data;
            npu_pkg::OP_MULI: result = (scaled > 16'd255) ? 8'hff : scaled[7:0];
            default:          op_writes = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (in_req) state <= READ;
                READ:    state <= EXEC;
                EXEC:    state <= ACK;
                ACK:     if (!in_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_req) begin
            instr_q <= in_instr;
            last_q  <= in_last;
        end
    end

    assign in_ack   = (state == ACK);
    assign prog_end = (state == ACK) && !in_req && last_q;
    assign host_sel = (state == IDLE);

    npu_sram #(
        .ADDR_W (8),
        .DATA_W (8)
    ) scratch_inst (
        .clk     (clk),
        .wr_en   (host_sel ? host_wr_en : (state == EXEC && op_writes)),
        .wr_addr (host_sel ? host_addr : dst_addr),
        .wr_data (host_sel ? host_wr_data : result),
        .rd_en   (host_sel ? host_rd_en : (state == READ)),
        .rd_addr (host_sel ? host_addr : src_addr),
        .rd_data (scr_rd_data)
    );

    assign host_rd_data = scr_rd_data;

endmodule

`default_nettype wire

// File: rtl/npu_top.sv
// NPU slice top: register port, microcode store, fetcher, queue and vector engine
// Host loads program and data, pulses start, then polls done
`timescale 1ns/10ps
`default_nettype none

module npu_top #(
    parameter int UCODE_ADDR_W = 8,
    parameter int QUEUE_DEPTH  = 4
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire npu_pkg::word_t  s_axi_awaddr,
    input  wire npu_pkg::word_t  s_axi_wdata,
    input  wire                  s_axi_wvalid,
    input  wire npu_pkg::word_t  s_axi_araddr,
    input  wire                  s_axi_arvalid,
    output npu_pkg::word_t       s_axi_rdata,
    output logic                 s_axi_rvalid,
    output logic                 busy,
    output logic                 done
);

    logic                       ucode_wr_en;
    npu_pkg::ucode_ptr_t        ucode_wr_addr;
    npu_pkg::word_t             ucode_wr_data;
    logic                       ucode_rd_en;
    logic [UCODE_ADDR_W-1:0]    ucode_rd_addr;
    npu_pkg::word_t             ucode_rd_data;
    logic                       scr_wr_en;
    logic                       scr_rd_en;
    npu_pkg::scr_addr_t         scr_addr;
    npu_pkg::data_t             scr_wr_data;
    npu_pkg::data_t             scr_rd_data;
    logic                       start;
    npu_pkg::ucode_ptr_t        ucode_base;
    npu_pkg::ucode_ptr_t        ucode_len;
    logic                       prog_end;
    logic                       in_req;
    logic                       in_ack;
    npu_pkg::instr_t            in_instr;
    logic                       in_last;
    logic                       out_req;
    logic                       out_ack;
    npu_pkg::instr_t            out_instr;
    logic                       out_last;

    npu_regs regs_inst (
        .clk (clk), .rst_n (rst_n),
        .s_axi_awaddr (s_axi_awaddr), .s_axi_wdata (s_axi_wdata),
        .s_axi_wvalid (s_axi_wvalid), .s_axi_araddr (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid), .s_axi_rdata (s_axi_rdata),
        .s_axi_rvalid (s_axi_rvalid),
        .ucode_wr_en (ucode_wr_en), .ucode_wr_addr (ucode_wr_addr),
        .ucode_wr_data (ucode_wr_data),
        .scr_wr_en (scr_wr_en), .scr_rd_en (scr_rd_en), .scr_addr (scr_addr),
        .scr_wr_data (scr_wr_data), .scr_rd_data (scr_rd_data),
        .start (start), .ucode_base (ucode_base), .ucode_len (ucode_len),
        .prog_end (prog_end), .busy (busy), .done (done)
    );

    // ============================================================
    // Microcode store and fetch pipeline
    // ============================================================
    npu_sram #(.ADDR_W (UCODE_ADDR_W), .DATA_W (32)) ucode_mem_inst (
        .clk (clk),
        .wr_en (ucode_wr_en), .wr_addr (ucode_wr_addr[UCODE_ADDR_W-1:0]),
        .wr_data (ucode_wr_data),
        .rd_en (ucode_rd_en), .rd_addr (ucode_rd_addr), .rd_data (ucode_rd_data)
    );

    ucode_fetch #(.UCODE_ADDR_W (UCODE_ADDR_W)) fetch_inst (
        .clk (clk), .rst_n (rst_n), .start (start),
        .ucode_base (ucode_base), .ucode_len (ucode_len),
        .mem_rd_en (ucode_rd_en), .mem_rd_addr (ucode_rd_addr),
        .mem_rd_data (ucode_rd_data),
        .out_req (in_req), .out_ack (in_ack), .out_instr (in_instr), .out_last (in_last)
    );

    instr_queue #(.QUEUE_DEPTH (QUEUE_DEPTH)) queue_inst (
        .clk (clk), .rst_n (rst_n),
        .in_req (in_req), .in_ack (in_ack), .in_instr (in_instr), .in_last (in_last),
        .out_req (out_req), .out_ack (out_ack), .out_instr (out_instr),
        .out_last (out_last)
    );

    vec_engine engine_inst (
        .clk (clk), .rst_n (rst_n),
        .in_req (out_req), .in_ack (out_ack), .in_instr (out_instr), .in_last (out_last),
        .prog_end (prog_end),
        .host_wr_en (scr_wr_en), .host_rd_en (scr_rd_en), .host_addr (scr_addr),
        .host_wr_data (scr_wr_data), .host_rd_data (scr_rd_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock and reset source for the NPU slice
// Reset is held low for a fixed number of rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/npu_tb.sv
// Directed tests of the NPU slice through its host register port
// Expected scratchpad bytes come from a byte-level model of the opcode rules
`timescale 1ns/10ps
`default_nettype none

module npu_tb;

    // Longest run is a few thousand cycles, so this leaves wide margin
    localparam int MAX_CYCLES  = 20000;
    localparam int DRIVE_DELAY = 10;

    logic            clk;
    logic            rst_n;
    npu_pkg::word_t  s_axi_awaddr;
    npu_pkg::word_t  s_axi_wdata;
    logic            s_axi_wvalid;
    npu_pkg::word_t  s_axi_araddr;
    logic            s_axi_arvalid;
    npu_pkg::word_t  s_axi_rdata;
    logic            s_axi_rvalid;
    logic            busy;
    logic            done;
    npu_pkg::data_t  model [256];
    npu_pkg::instr_t prog [$];
    int unsigned     cycles = 0;

    tb_clock #(.PERIOD_NS (100), .RESET_CYCLES (2)) clock_inst (.clk (clk), .rst_n (rst_n));

    npu_top #(.UCODE_ADDR_W (8), .QUEUE_DEPTH (4)) npu_top_inst (
        .clk (clk), .rst_n (rst_n),
        .s_axi_awaddr (s_axi_awaddr), .s_axi_wdata (s_axi_wdata),
        .s_axi_wvalid (s_axi_wvalid), .s_axi_araddr (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid), .s_axi_rdata (s_axi_rdata),
        .s_axi_rvalid (s_axi_rvalid), .busy (busy), .done (done)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) fail_run("timeout: run did not finish in the cycle limit");
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_word(input string name, input npu_pkg::word_t expected,
                              input npu_pkg::word_t actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_byte(input string name, input npu_pkg::data_t expected,
                              input npu_pkg::data_t actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s: expected %b actual %b", name, expected, actual));
    endtask

    // ============================================================
    // Host port access
    // ============================================================
    function automatic npu_pkg::word_t reg_addr(input npu_pkg::reg_idx_t idx);
        return {26'd0, idx, 2'b00};
    endfunction

    task automatic write_reg(input npu_pkg::reg_idx_t idx, input npu_pkg::word_t data);
        s_axi_awaddr = reg_addr(idx);
        s_axi_wdata  = data;
        s_axi_wvalid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        s_axi_wvalid = 1'b0;
    endtask

    task automatic read_reg(input npu_pkg::reg_idx_t idx, output npu_pkg::word_t data);
        s_axi_araddr  = reg_addr(idx);
        s_axi_arvalid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        data = s_axi_rdata;
    endtask

    task automatic write_scr(input npu_pkg::scr_addr_t addr, input npu_pkg::data_t data);
        write_reg(npu_pkg::REG_SCR_ADDR, 32'(addr));
        write_reg(npu_pkg::REG_SCR_DATA, 32'(data));
        model[addr] = data;
    endtask

    task automatic compare_scr(input string name, input npu_pkg::scr_addr_t addr);
        npu_pkg::word_t rd;
        write_reg(npu_pkg::REG_SCR_ADDR, 32'(addr));
        read_reg(npu_pkg::REG_SCR_DATA, rd);
        check_byte($sformatf("%s byte %02h", name, addr), model[addr], rd[7:0]);
    endtask

    // ============================================================
    // Instruction encoding and reference model
    // ============================================================
    function automatic npu_pkg::instr_t make_instr(input logic [3:0] op,
            input logic [7:0] dst, input logic [7:0] src, input logic [7:0] imm);
        return {op, 4'd0, dst, src, imm};
    endfunction

    task automatic model_exec(input npu_pkg::instr_t ins);
        logic [3:0]  op;
        logic [7:0]  dst;
        logic [7:0]  src;
        logic [7:0]  imm;
        int unsigned val;
        op  = ins[31:28];
        dst = ins[23:16];
        src = ins[15:8];
        imm = ins[7:0];
        case (op)
            npu_pkg::OP_ADDI: model[dst] = 8'((32'(model[src]) + 32'(imm)) % 256);
            npu_pkg::OP_COPY: model[dst] = model[src];
            npu_pkg::OP_MULI: begin
                val = (32'(model[src]) * 32'(imm)) >> npu_pkg::REQUANT_SHIFT;
                model[dst] = (val > 255) ? 8'hff : 8'(val);
            end
            default: ;
        endcase
    endtask

    task automatic wait_done();
        npu_pkg::word_t rd;
        rd = '0;
        while (!rd[1]) read_reg(npu_pkg::REG_STATUS, rd);
    endtask

    // Load prog at base, start it, check busy during and done after
    task automatic run_program(input string name, input npu_pkg::ucode_ptr_t base);
        npu_pkg::word_t rd;
        write_reg(npu_pkg::REG_UCODE_WADDR, 32'(base));
        foreach (prog[i]) write_reg(npu_pkg::REG_UCODE_WDATA, prog[i]);
        write_reg(npu_pkg::REG_UCODE_BASE, 32'(base));
        write_reg(npu_pkg::REG_UCODE_LEN, 32'(prog.size()));
        write_reg(npu_pkg::REG_CTRL, 32'h1);
        foreach (prog[i]) model_exec(prog[i]);
        read_reg(npu_pkg::REG_STATUS, rd);
        check_word({name, " status running"}, 32'h1, rd);
        wait_done();
        read_reg(npu_pkg::REG_STATUS, rd);
        check_word({name, " status finished"}, 32'h2, rd);
        check_flag({name, " busy port"}, 1'b0, busy);
        check_flag({name, " done port"}, 1'b1, done);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic reg_readback();
        npu_pkg::word_t rd;
        read_reg(npu_pkg::REG_STATUS, rd);
        check_word("reset status", 32'h0, rd);
        write_reg(npu_pkg::REG_UCODE_BASE, 32'h0000_1234);
        write_reg(npu_pkg::REG_UCODE_LEN, 32'h0000_0007);
        read_reg(npu_pkg::REG_UCODE_BASE, rd);
        check_word("ucode base readback", 32'h0000_1234, rd);
        read_reg(npu_pkg::REG_UCODE_LEN, rd);
        check_word("ucode len readback", 32'h0000_0007, rd);
    endtask

    task automatic scratch_access();
        npu_pkg::word_t     rd;
        npu_pkg::scr_addr_t addr;
        for (int i = 0; i < 8; i++) write_scr(8'(i * 37 + 5), 8'($urandom));
        for (int i = 0; i < 8; i++) begin
            addr = 8'(i * 37 + 5);
            compare_scr("scratch readback", addr);
        end
        write_reg(npu_pkg::REG_UCODE_LEN, 32'h0);
        write_reg(npu_pkg::REG_CTRL, 32'h1);
        read_reg(npu_pkg::REG_STATUS, rd);
        check_flag("empty start busy", 1'b0, rd[0]);
        check_flag("empty start busy port", 1'b0, busy);
    endtask

    task automatic chained_program();
        write_scr(8'h10, 8'hf0);
        write_scr(8'h20, 8'h7e);
        prog.delete();
        // 0xf0 + 0x25 and 0x7e + 0x82 both wrap past 255
        prog.push_back(make_instr(npu_pkg::OP_ADDI, 8'h11, 8'h10, 8'h25));
        prog.push_back(make_instr(npu_pkg::OP_COPY, 8'h12, 8'h11, 8'h00));
        // NOP aimed at a later source byte
        prog.push_back(make_instr(npu_pkg::OP_NOP,  8'h20, 8'h10, 8'h99));
        prog.push_back(make_instr(npu_pkg::OP_ADDI, 8'h12, 8'h12, 8'h03));
        prog.push_back(make_instr(npu_pkg::OP_ADDI, 8'h21, 8'h20, 8'h82));
        prog.push_back(make_instr(npu_pkg::OP_COPY, 8'h13, 8'h12, 8'h00));
        run_program("chain", 16'h0014);
        compare_scr("chain", 8'h10);
        compare_scr("chain", 8'h11);
        compare_scr("chain", 8'h12);
        compare_scr("chain", 8'h13);
        compare_scr("chain", 8'h20);
        compare_scr("chain", 8'h21);
    endtask

    task automatic muli_requant();
        write_scr(8'h30, 8'h05);
        write_scr(8'h31, 8'hc8);
        write_scr(8'h32, 8'hff);
        write_scr(8'h33, 8'h10);
        prog.delete();
        prog.push_back(make_instr(npu_pkg::OP_MULI, 8'h34, 8'h30, 8'h30));
        prog.push_back(make_instr(npu_pkg::OP_MULI, 8'h35, 8'h31, 8'h40));
        prog.push_back(make_instr(npu_pkg::OP_MULI, 8'h36, 8'h32, 8'hff));
        prog.push_back(make_instr(npu_pkg::OP_MULI, 8'h37, 8'h33, 8'h0b));
        run_program("muli", 16'h0040);
        for (int a = 8'h34; a <= 8'h37; a++) compare_scr("muli", 8'(a));
        check_byte("muli small literal", 8'd15, model[8'h34]);
        check_byte("muli saturate literal", 8'hff, model[8'h35]);
    endtask

    // More instructions than queue slots, so the fetcher sees back-pressure
    task automatic random_program();
        for (int a = 0; a < 256; a++) write_scr(8'(a), 8'($urandom));
        prog.delete();
        for (int i = 0; i < 20; i++)
            prog.push_back(make_instr(4'($urandom % 5), 8'($urandom), 8'($urandom),
                                      8'($urandom)));
        run_program("random first", 16'h0080);
        for (int a = 0; a < 256; a++) compare_scr("random first", 8'(a));
        run_program("random second", 16'h0080);
        for (int a = 0; a < 256; a++) compare_scr("random second", 8'(a));
    endtask

    initial begin
        s_axi_awaddr  = '0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        void'($urandom(32'hbe3e));
        @(posedge rst_n);
        @(posedge clk);
        #DRIVE_DELAY;
        reg_readback();
        scratch_access();
        chained_program();
        muli_requant();
        random_program();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/npu_pkg.sv
rtl/npu_sram.sv
rtl/npu_regs.sv
controller/ucode_fetch.sv
controller/instr_queue.sv
engine/vec_engine.sv
rtl/npu_top.sv
tests/tb_clock.sv
tests/npu_tb.sv

// File: run.sh
#!/bin/sh
# Build the NPU slice testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module npu_tb -o npu_sim

./obj_dir/npu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
grep -qF '*** PASSED ***' sim.log
